//--- source/mdio_params.svh
`ifndef MDIO_PARAMS_SVH
`define MDIO_PARAMS_SVH

// Width of the MDC divider counter
// MDC period is 2**MDIO_CLKBITS system clocks
`define MDIO_CLKBITS 2

// Ones sent after reset before the first frame
`define MDIO_PREAMBLE_BITS 64

// Management frame length in bits
`define MDIO_FRAME_BITS 32

// Field widths
`define MDIO_FIELD_BITS 5
`define MDIO_DATA_BITS 16
`define MDIO_COUNT_BITS 7

// XORed into the upper five bus address bits
`define MDIO_PHY_ADDR 5'h00

`endif

//--- source/mdio_pkg.sv
`default_nettype none

`include "mdio_params.svh"

package mdio_pkg;

	// Wishbone word address, PHY field over register field
	typedef logic [2*`MDIO_FIELD_BITS-1:0] wb_addr_t;

	// PHY or register address field
	typedef logic [`MDIO_FIELD_BITS-1:0] mdio_field_t;

	typedef logic [`MDIO_DATA_BITS-1:0] mdio_data_t;

	// Bits left in the current phase, sized for the preamble
	typedef logic [`MDIO_COUNT_BITS-1:0] bit_count_t;

	// One accepted bus request
	typedef struct packed {
		logic       write;
		wb_addr_t   addr;
		mdio_data_t data;
	} mdio_req_t;

	typedef enum logic [2:0] {
		PREAMBLE,
		IDLE,
		HEADER,
		READ_DATA,
		WRITE_DATA
	} mdio_state_e;

endpackage

`default_nettype wire

//--- source/mdio_clkgen.sv
`timescale 1ns/10ps
`default_nettype none

`include "mdio_params.svh"

module mdio_clkgen
(
	input  wire logic i_clk,
	input  wire logic i_reset,
	output logic      o_mdclk,
	output logic      o_bit_strobe
);

	localparam int CLKBITS = `MDIO_CLKBITS;

	// Last count before the wrap
	localparam logic [CLKBITS-1:0] STROBE_AT = {CLKBITS{1'b1}} - 1'b1;

	logic [CLKBITS-1:0] div_count;

	// Free-running divider
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			div_count <= '0;
		else
			div_count <= div_count + 1'b1;
	end

	assign o_mdclk = div_count[CLKBITS-1];

	// Registered decode, so the strobe sits in the last high MDC cycle
	// and everything it enables moves on the falling edge
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_bit_strobe <= 1'b0;
		else
			o_bit_strobe <= (div_count == STROBE_AT);
	end

endmodule

`default_nettype wire

//--- source/mdio_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "mdio_params.svh"

module mdio_ctrl
	import mdio_pkg::*;
(
	input  wire logic        i_clk,
	input  wire logic        i_reset,
	input  wire logic        i_bit_strobe,
	input  wire logic        i_wb_cyc,
	input  wire logic        i_wb_stb,
	input  wire logic        i_wb_we,
	input  wire wb_addr_t    i_wb_addr,
	input  wire logic [31:0] i_wb_data,
	output logic             o_wb_stall,
	output logic             o_wb_ack,
	output mdio_req_t        o_req,
	output logic             o_load_header,
	output logic             o_load_data,
	output logic             o_capture_done,
	output logic             o_mdwe
);

	localparam int DW = $bits(mdio_data_t);

	localparam bit_count_t PREAMBLE_LAST = bit_count_t'(`MDIO_PREAMBLE_BITS - 1);
	localparam bit_count_t HEADER_LAST = bit_count_t'(`MDIO_FRAME_BITS / 2 - 1);
	localparam bit_count_t DATA_LAST = bit_count_t'(`MDIO_DATA_BITS - 1);

	// Count still left when the first turnaround bit goes out
	localparam bit_count_t TA_COUNT = bit_count_t'(2);

	mdio_state_e state;
	bit_count_t  bit_cnt;
	logic        pending;
	logic        pre_ack;
	logic        frame_done;
	logic        accept;
	logic        last_bit;
	logic        frame_end;

	assign accept = i_wb_stb && !o_wb_stall;
	assign last_bit = i_bit_strobe && (bit_cnt == '0);
	assign frame_end = last_bit && ((state == READ_DATA) || (state == WRITE_DATA));

	assign o_load_header = i_bit_strobe && (state == IDLE) && pending;
	assign o_load_data = last_bit && (state == HEADER) && o_req.write;
	assign o_capture_done = last_bit && (state == READ_DATA);

	////////////////////////////////////////
	// Request side
	////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (accept)
		begin
			o_req.write <= i_wb_we;
			o_req.addr <= i_wb_addr;
			o_req.data <= i_wb_data[DW-1:0];
		end
	end

	// Request waiting for the next strobe
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			pending <= 1'b0;
		else if (accept)
			pending <= 1'b1;
		else if (o_load_header)
			pending <= 1'b0;
	end

	// Dropping cyc abandons the ack but not the frame
	always_ff @(posedge i_clk)
	begin
		if (i_reset || !i_wb_cyc)
			pre_ack <= 1'b0;
		else if (accept)
			pre_ack <= 1'b1;
		else if (frame_end)
			pre_ack <= 1'b0;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			frame_done <= 1'b0;
			o_wb_ack <= 1'b0;
		end
		else
		begin
			frame_done <= frame_end;
			o_wb_ack <= frame_end && pre_ack && i_wb_cyc;
		end
	end

	// Held through the ack cycle and low one cycle later
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_wb_stall <= 1'b1;
		else if (accept)
			o_wb_stall <= 1'b1;
		else if (frame_done)
			o_wb_stall <= 1'b0;
		else if ((state == PREAMBLE) && last_bit)
			o_wb_stall <= 1'b0;
	end

	////////////////////////////////////////
	// Frame sequencing
	////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			state <= PREAMBLE;
			bit_cnt <= PREAMBLE_LAST;
			o_mdwe <= 1'b1;
		end
		else
		begin
			if (i_bit_strobe && (bit_cnt != '0))
				bit_cnt <= bit_cnt - 1'b1;

			case (state)
			PREAMBLE:
			begin
				if (last_bit)
					state <= IDLE;
			end
			IDLE:
			begin
				if (o_load_header)
				begin
					state <= HEADER;
					bit_cnt <= HEADER_LAST;
				end
			end
			HEADER:
			begin
				// Release the line for both turnaround bits of a read
				if (i_bit_strobe && !o_req.write && (bit_cnt == TA_COUNT))
					o_mdwe <= 1'b0;
				if (last_bit)
				begin
					state <= o_req.write ? WRITE_DATA : READ_DATA;
					bit_cnt <= DATA_LAST;
				end
			end
			READ_DATA, WRITE_DATA:
			begin
				if (last_bit)
				begin
					state <= IDLE;
					o_mdwe <= 1'b1;
				end
			end
			default:
			begin
				state <= PREAMBLE;
				bit_cnt <= PREAMBLE_LAST;
			end
			endcase
		end
	end

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	a_ack_after_data: assert property (@(posedge i_clk) disable iff (i_reset)
		o_wb_ack |-> (state == IDLE)
			&& $past((state == READ_DATA) || (state == WRITE_DATA)));

	a_stall_busy: assert property (@(posedge i_clk) disable iff (i_reset)
		(state != IDLE) |-> o_wb_stall);

	a_state_legal: assert property (@(posedge i_clk) disable iff (i_reset)
		state inside {PREAMBLE, IDLE, HEADER, READ_DATA, WRITE_DATA});

endmodule

`default_nettype wire

//--- source/mdio_tx_shift.sv
`timescale 1ns/10ps
`default_nettype none

`include "mdio_params.svh"

module mdio_tx_shift
	import mdio_pkg::*;
(
	input  wire logic      i_clk,
	input  wire logic      i_reset,
	input  wire logic      i_bit_strobe,
	input  wire mdio_req_t i_req,
	input  wire logic      i_load_header,
	input  wire logic      i_load_data,
	output logic           o_mdio
);

	localparam int DW = $bits(mdio_data_t);
	localparam int FW = $bits(mdio_field_t);

	mdio_field_t phy_field;
	mdio_field_t reg_field;
	mdio_data_t  header;
	mdio_data_t  next_word;
	mdio_data_t  shift_reg;

	assign phy_field = i_req.addr[2*FW-1:FW] ^ `MDIO_PHY_ADDR;
	assign reg_field = i_req.addr[FW-1:0];

	// Start, opcode, PHY, register, turnaround
	assign header = {
		2'b01,
		i_req.write ? 2'b01 : 2'b10,
		phy_field,
		reg_field,
		i_req.write ? 2'b10 : 2'b11
	};

	always_comb
	begin
		if (i_load_header)
			next_word = header;
		else if (i_load_data)
			next_word = i_req.data;
		else
			next_word = shift_reg;
	end

	// MSB first, ones shifted in behind so the line idles high
	// and the preamble falls out of reset for free
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			shift_reg <= '1;
			o_mdio <= 1'b1;
		end
		else if (i_bit_strobe)
		begin
			o_mdio <= next_word[DW-1];
			shift_reg <= {next_word[DW-2:0], 1'b1};
		end
	end

	a_mdio_on_strobe: assert property (@(posedge i_clk) disable iff (i_reset)
		!$past(i_bit_strobe) |-> $stable(o_mdio));

endmodule

`default_nettype wire

//--- source/mdio_rx_capture.sv
`timescale 1ns/10ps
`default_nettype none

module mdio_rx_capture
	import mdio_pkg::*;
(
	input  wire logic i_clk,
	input  wire logic i_bit_strobe,
	input  wire logic i_mdio,
	input  wire logic i_capture_done,
	output mdio_data_t o_rd_data
);

	localparam int DW = $bits(mdio_data_t);

	mdio_data_t shift_reg;
	mdio_data_t sampled;

	// Shift register with the bit being sampled now
	assign sampled = {shift_reg[DW-2:0], i_mdio};

	// Sampled on falling MDC, the PHY moves on the rising edge
	always_ff @(posedge i_clk)
	begin
		if (i_bit_strobe)
			shift_reg <= sampled;
	end

	// Held until the next read completes
	always_ff @(posedge i_clk)
	begin
		if (i_capture_done)
			o_rd_data <= sampled;
	end

endmodule

`default_nettype wire

//--- source/mdio_bridge.sv
`timescale 1ns/10ps
`default_nettype none

module mdio_bridge
	import mdio_pkg::*;
(
	input  wire logic        i_clk,
	input  wire logic        i_reset,

	// Wishbone slave, pipelined with stall
	input  wire logic        i_wb_cyc,
	input  wire logic        i_wb_stb,
	input  wire logic        i_wb_we,
	input  wire wb_addr_t    i_wb_addr,
	input  wire logic [31:0] i_wb_data,
	output logic             o_wb_stall,
	output logic             o_wb_ack,
	output logic [31:0]      o_wb_data,

	// PHY management pins
	output logic             o_mdclk,
	output logic             o_mdio,
	input  wire logic        i_mdio,
	output logic             o_mdwe
);

	logic       bit_strobe;
	mdio_req_t  req;
	logic       load_header;
	logic       load_data;
	logic       capture_done;
	mdio_data_t rd_data;

	////////////////////////////////////////
	// MDC and bit timing
	////////////////////////////////////////

	mdio_clkgen u_clkgen
	(
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.o_mdclk      (o_mdclk),
		.o_bit_strobe (bit_strobe)
	);

	////////////////////////////////////////
	// Control
	////////////////////////////////////////

	mdio_ctrl u_ctrl
	(
		.i_clk          (i_clk),
		.i_reset        (i_reset),
		.i_bit_strobe   (bit_strobe),
		.i_wb_cyc       (i_wb_cyc),
		.i_wb_stb       (i_wb_stb),
		.i_wb_we        (i_wb_we),
		.i_wb_addr      (i_wb_addr),
		.i_wb_data      (i_wb_data),
		.o_wb_stall     (o_wb_stall),
		.o_wb_ack       (o_wb_ack),
		.o_req          (req),
		.o_load_header  (load_header),
		.o_load_data    (load_data),
		.o_capture_done (capture_done),
		.o_mdwe         (o_mdwe)
	);

	////////////////////////////////////////
	// Data paths
	////////////////////////////////////////

	mdio_tx_shift u_tx
	(
		.i_clk         (i_clk),
		.i_reset       (i_reset),
		.i_bit_strobe  (bit_strobe),
		.i_req         (req),
		.i_load_header (load_header),
		.i_load_data   (load_data),
		.o_mdio        (o_mdio)
	);

	mdio_rx_capture u_rx
	(
		.i_clk          (i_clk),
		.i_bit_strobe   (bit_strobe),
		.i_mdio         (i_mdio),
		.i_capture_done (capture_done),
		.o_rd_data      (rd_data)
	);

	// Read word zero-extended onto the bus
	assign o_wb_data = {{(32 - $bits(mdio_data_t)){1'b0}}, rd_data};

endmodule

`default_nettype wire

//--- verification/mdio_bridge_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "mdio_params.svh"

module mdio_bridge_tb
	import mdio_pkg::*;
();

	localparam int NUM_TRANS = 200;
	localparam int CYCLES_PER_TRANS = 140;
	// Preamble plus every frame with room for gaps and stalls
	localparam int TIMEOUT_CYCLES = NUM_TRANS * CYCLES_PER_TRANS + 12000;
	localparam logic [4:0] PHY_ADDR = `MDIO_PHY_ADDR;
	localparam int MDC_PERIOD = 2 ** `MDIO_CLKBITS;

	logic        clk;
	logic        reset;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	wb_addr_t    wb_addr;
	logic [31:0] wb_wdata;
	logic        stall;
	logic        ack;
	logic [31:0] wb_rdata;
	logic        mdclk;
	logic        mdio_out;
	logic        mdio_in;
	logic        mdwe;

	logic [31:0] lfsr_state;
	int          cycle_count;
	int          ack_total;
	int          acks_expected;
	int          accept_count;
	int          frames_started;
	int          frames_done;

	// Request currently on the bus as the PHY should see it
	logic        exp_we;
	wb_addr_t    exp_addr;
	logic [15:0] exp_data;

	// Last value written per address and the PHY's own registers
	logic [15:0] model_mem [0:1023];
	logic [15:0] phy_regs [0:1023];

	// PHY responder state
	logic        phy_enable;
	logic        in_frame;
	int          bit_idx;
	logic [31:0] frame_bits;
	logic        frame_read;
	wb_addr_t    frame_addr;
	logic [15:0] rd_word;

	// MDC timing monitor
	logic        mdc_prev;
	logic        mdio_prev;
	int          mdc_count;

	mdio_bridge u_mdio_bridge
	(
		.i_clk      (clk),
		.i_reset    (reset),
		.i_wb_cyc   (wb_cyc),
		.i_wb_stb   (wb_stb),
		.i_wb_we    (wb_we),
		.i_wb_addr  (wb_addr),
		.i_wb_data  (wb_wdata),
		.o_wb_stall (stall),
		.o_wb_ack   (ack),
		.o_wb_data  (wb_rdata),
		.o_mdclk    (mdclk),
		.o_mdio     (mdio_out),
		.i_mdio     (mdio_in),
		.o_mdwe     (mdwe)
	);

	always #20 clk = ~clk;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected)
		begin
			$display("ERR %0t: %s, got %h, expected %h", $time, what, actual, expected);
			$display("TB FAILED");
			$fatal(1);
		end
	endtask

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
			$display("TB FAILED");
			$fatal(1);
		end
	end

	always @(posedge clk)
	begin
		if (!reset && ack)
			ack_total++;
	end

	////////////////////////////////////////
	// MDC period and edge placement
	////////////////////////////////////////

	always @(posedge clk)
	begin
		if (reset)
		begin
			mdc_prev <= 1'b0;
			mdio_prev <= 1'b1;
			mdc_count <= 0;
		end
		else
		begin
			mdc_prev <= mdclk;
			mdio_prev <= mdio_out;
			if (mdclk && !mdc_prev)
			begin
				if (mdc_count != 0)
					check_eq(mdc_count, MDC_PERIOD, "MDC period");
				mdc_count <= 1;
			end
			else if (mdc_count != 0)
				mdc_count <= mdc_count + 1;
			// The line moves only just after MDC falls
			if (mdio_out !== mdio_prev)
				check_eq(32'({mdc_prev, mdclk}), 32'b10,
					"o_mdio moved away from the falling MDC edge");
		end
	end

	////////////////////////////////////////
	// PHY responder on rising MDC
	////////////////////////////////////////

	always @(posedge mdclk)
	begin
		if (phy_enable && !in_frame)
		begin
			mdio_in <= 1'b1;
			check_eq(32'(mdwe), 32'd1, "o_mdwe low between frames");
			if (mdio_out == 1'b0)
			begin
				in_frame = 1'b1;
				bit_idx = 1;
				frame_bits = '0;
				frame_read = 1'b0;
				frames_started++;
				check_eq(frames_started, accept_count, "frame started without a request");
			end
		end
		else if (phy_enable)
		begin
			frame_bits[31 - bit_idx] = mdio_out;
			// Header fields are complete after the register address
			if (bit_idx == 13)
			begin
				frame_read = (frame_bits[29:28] == 2'b10);
				frame_addr = {frame_bits[27:23] ^ PHY_ADDR, frame_bits[22:18]};
				rd_word = phy_regs[frame_addr];
				check_eq(32'(frame_bits[31:30]), 32'h1, "start pattern");
				check_eq(32'(frame_bits[29:28]), exp_we ? 32'h1 : 32'h2, "opcode");
				check_eq(32'(frame_bits[27:23]), 32'(exp_addr[9:5] ^ PHY_ADDR), "PHY field");
				check_eq(32'(frame_bits[22:18]), 32'(exp_addr[4:0]), "register field");
			end
			check_eq(32'(mdwe), (bit_idx >= 14 && frame_read) ? 32'd0 : 32'd1, "o_mdwe");
			if (frame_read && bit_idx == 15)
				mdio_in <= 1'b0;
			if (frame_read && bit_idx >= 16)
				mdio_in <= rd_word[31 - bit_idx];
			if (bit_idx == 31)
			begin
				if (!frame_read)
				begin
					check_eq(32'(frame_bits[17:16]), 32'h2, "write turnaround");
					check_eq(32'(frame_bits[15:0]), 32'(exp_data), "write data");
					phy_regs[frame_addr] = frame_bits[15:0];
				end
				frames_done++;
				in_frame = 1'b0;
			end
			bit_idx++;
		end
	end

	////////////////////////////////////////
	// Bus side
	////////////////////////////////////////

	task automatic do_transfer(input logic we, input wb_addr_t addr, input logic [31:0] data,
		input logic drop);
		logic got_ack;
		@(posedge clk);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= we;
		wb_addr <= addr;
		wb_wdata <= data;
		exp_we = we;
		exp_addr = addr;
		exp_data = data[15:0];
		// Held until the bridge takes it
		do
			@(posedge clk);
		while (stall);
		wb_stb <= 1'b0;
		accept_count++;
		if (drop)
		begin
			wait (frames_started == accept_count);
			@(posedge clk);
			wb_cyc <= 1'b0;
			wait (frames_done == accept_count);
			do
			begin
				@(posedge clk);
				check_eq(32'(ack), 32'd0, "ack given after cyc dropped");
			end
			while (stall);
			model_mem[addr] = data[15:0];
		end
		else
		begin
			got_ack = 1'b0;
			while (!got_ack)
			begin
				@(posedge clk);
				check_eq(32'(stall), 32'd1, "stall low with a request in flight");
				got_ack = ack;
			end
			wb_cyc <= 1'b0;
			acks_expected++;
			check_eq(frames_done, accept_count, "ack without a finished frame");
			if (we)
				model_mem[addr] = data[15:0];
			else
				check_eq(wb_rdata, {16'h0000, model_mem[addr]}, "read data");
			@(posedge clk);
			check_eq(32'(stall), 32'd0, "stall high after the ack");
			check_eq(32'(ack), 32'd0, "ack longer than one cycle");
		end
	endtask

	initial
	begin
		logic        t_we;
		logic        t_drop;
		wb_addr_t    t_addr;
		logic [31:0] t_data;
		logic [31:0] r;
		clk = 1'b0;
		reset = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_addr = '0;
		wb_wdata = '0;
		mdio_in = 1'b1;
		lfsr_state = 32'hbd5f_2d22;
		cycle_count = 0;
		ack_total = 0;
		acks_expected = 0;
		accept_count = 0;
		frames_started = 0;
		frames_done = 0;
		phy_enable = 1'b0;
		in_frame = 1'b0;
		for (int i = 0; i < 1024; i++)
		begin
			model_mem[i] = '0;
			phy_regs[i] = '0;
		end
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		phy_enable = 1'b1;

		// Preamble of ones with the bus held off
		repeat (`MDIO_PREAMBLE_BITS)
		begin
			@(posedge mdclk);
			check_eq(32'(mdio_out), 32'd1, "o_mdio low during preamble");
			check_eq(32'(mdwe), 32'd1, "o_mdwe low during preamble");
			check_eq(32'(stall), 32'd1, "stall low during preamble");
		end
		check_eq(ack_total, 0, "ack during preamble");

		for (int n = 0; n < NUM_TRANS; n++)
		begin
			r = rand_bits(1);
			t_we = r[0];
			if (rand_bits(1) == 32'd1)
				t_addr = wb_addr_t'(rand_bits(10));
			else
			begin
				// Small pool so reads often land on earlier writes
				r = rand_bits(5);
				t_addr = {r[4:3], 5'b10101, r[2:0]};
			end
			t_data = rand_bits(32);
			t_drop = t_we && (rand_bits(4) == 32'd0);
			do_transfer(t_we, t_addr, t_data, t_drop);
			repeat (rand_bits(2)) @(posedge clk);
		end

		repeat (4) @(posedge clk);
		check_eq(ack_total, acks_expected, "total ack count");
		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- mdio_bridge.f
+incdir+source
source/mdio_pkg.sv
source/mdio_clkgen.sv
source/mdio_ctrl.sv
source/mdio_tx_shift.sv
source/mdio_rx_capture.sv
source/mdio_bridge.sv
verification/mdio_bridge_tb.sv

//--- Makefile
# Verilator build and run of the MDIO bridge testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f mdio_bridge.f \
		--top-module mdio_bridge_tb -o sim_mdio_bridge

run: compile
	./obj_dir/sim_mdio_bridge | tee sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
